// ==== flist.f ====
+incdir+hdl
hdl/cnn_pkg.sv
hdl/cnn_ifs.sv
hdl/sram_dp.sv
hdl/layer_sequencer.sv
hdl/dram_loader.sv
hdl/window_scanner.sv
hdl/conv_pool_unit.sv
hdl/cnn_layer_top.sv
test/tb_cnn_layer.sv

// ==== hdl/cnn_ifs.sv ====
// loader side of the weight buffer and the two pixel banks
interface buf_fill_if
    import cnn_pkg::*;
();
    logic       pix_we;
    bank_addr_t pix_addr;
    pixel_t     pix_even;
    pixel_t     pix_odd;
    logic       w_we;
    tap_idx_t   w_addr;
    weight_t    w_data;

    modport filler (
        output pix_we, pix_addr, pix_even, pix_odd,
        output w_we, w_addr, w_data
    );
endinterface

// one tap per valid cycle, scanner to conv unit
interface tap_stream_if
    import cnn_pkg::*;
();
    logic    tap_valid;
    pixel_t  pixel;
    weight_t weight;
    logic    last_tap;
    logic    quad_last;

    modport source (output tap_valid, pixel, weight, last_tap, quad_last);
    modport sink   (input  tap_valid, pixel, weight, last_tap, quad_last);
endinterface

// ==== hdl/cnn_layer_top.sv ====
`include "cnn_settings.svh"

module cnn_layer_top
    import cnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  dram_addr_t i_rd_base,
    input  dram_addr_t i_wr_base,
    output dram_addr_t o_rd_addr1,
    output dram_addr_t o_rd_addr2,
    input  pixel_t     i_rd_data1,
    input  pixel_t     i_rd_data2,
    output logic       o_wr_en,
    output dram_addr_t o_wr_addr,
    output pixel_t     o_wr_data,
    output logic       o_done
);

    localparam int BANK_DEPTH = `FMAP_DIM * `FMAP_DIM / 2;

    buf_fill_if   fill_bus ();
    tap_stream_if tap_bus ();

    dram_addr_t rd_base;
    dram_addr_t wr_base;
    logic       load_done;
    logic       scan_start;
    logic       last_write;
    bank_addr_t bank_raddr;
    tap_idx_t   w_raddr;
    pixel_t     bank_even_q;
    pixel_t     bank_odd_q;
    weight_t    weight_q;

    layer_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .i_rd_base    (i_rd_base),
        .i_wr_base    (i_wr_base),
        .i_load_done  (load_done),
        .i_last_write (last_write),
        .o_rd_base    (rd_base),
        .o_wr_base    (wr_base),
        .o_scan_start (scan_start),
        .o_done       (o_done)
    );

    dram_loader u_loader (
        .clk         (clk),
        .reset       (reset),
        .i_rd_base   (rd_base),
        .i_rd_data1  (i_rd_data1),
        .i_rd_data2  (i_rd_data2),
        .o_rd_addr1  (o_rd_addr1),
        .o_rd_addr2  (o_rd_addr2),
        .o_load_done (load_done),
        .fill        (fill_bus.filler)
    );

    // column-parity banks share the loader address
    sram_dp #(.T_WORD(pixel_t), .DEPTH(BANK_DEPTH)) u_bank_even (
        .clk     (clk),
        .i_we    (fill_bus.pix_we),
        .i_waddr (fill_bus.pix_addr),
        .i_wdata (fill_bus.pix_even),
        .i_raddr (bank_raddr),
        .o_rdata (bank_even_q)
    );

    sram_dp #(.T_WORD(pixel_t), .DEPTH(BANK_DEPTH)) u_bank_odd (
        .clk     (clk),
        .i_we    (fill_bus.pix_we),
        .i_waddr (fill_bus.pix_addr),
        .i_wdata (fill_bus.pix_odd),
        .i_raddr (bank_raddr),
        .o_rdata (bank_odd_q)
    );

    sram_dp #(.T_WORD(weight_t), .DEPTH(`KERNEL_TAPS)) u_wbuf (
        .clk     (clk),
        .i_we    (fill_bus.w_we),
        .i_waddr (fill_bus.w_addr),
        .i_wdata (fill_bus.w_data),
        .i_raddr (w_raddr),
        .o_rdata (weight_q)
    );

    // end of layer is taken from the last write, not the scan
    window_scanner u_scanner (
        .clk          (clk),
        .reset        (reset),
        .i_scan_start (scan_start),
        .i_bank_even  (bank_even_q),
        .i_bank_odd   (bank_odd_q),
        .i_weight     (weight_q),
        .o_bank_raddr (bank_raddr),
        .o_w_raddr    (w_raddr),
        .o_scan_done  (),
        .taps         (tap_bus.source)
    );

    conv_pool_unit u_conv (
        .clk          (clk),
        .reset        (reset),
        .i_wr_base    (wr_base),
        .o_wr_en      (o_wr_en),
        .o_wr_addr    (o_wr_addr),
        .o_wr_data    (o_wr_data),
        .o_last_write (last_write),
        .taps         (tap_bus.sink)
    );

endmodule

// ==== hdl/cnn_pkg.sv ====
`include "cnn_settings.svh"

package cnn_pkg;

    typedef logic signed [`PIX_W-1:0] pixel_t;
    typedef logic signed [`PIX_W-1:0] weight_t;
    typedef logic signed [`ACC_W-1:0] acc_t;

    typedef logic [`DRAM_AW-1:0] dram_addr_t;

    // one column-parity bank holds half the image
    typedef logic [$clog2(`FMAP_DIM*`FMAP_DIM/2)-1:0] bank_addr_t;
    typedef logic [$clog2(`KERNEL_TAPS)-1:0] tap_idx_t;
    typedef logic [$clog2(`FMAP_DIM)-1:0] coord_t;

    typedef enum logic [1:0]
    {
        PH_LOAD,
        PH_COMPUTE,
        PH_DONE
    } layer_phase_e;

endpackage

// ==== hdl/cnn_settings.svh ====
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// square image side
`define FMAP_DIM 8

// pixel and weight width
`define PIX_W 8

// wide enough for nine 8x8 products
`define ACC_W 20

`define DRAM_AW 16
`define KERNEL_TAPS 9

// pixels start right after the nine weights
`define PIX_OFFSET 9
`define OUT_MAX 127

`endif

// ==== hdl/conv_pool_unit.sv ====
`include "cnn_settings.svh"

module conv_pool_unit
    import cnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  dram_addr_t i_wr_base,
    output logic       o_wr_en,
    output dram_addr_t o_wr_addr,
    output pixel_t     o_wr_data,
    output logic       o_last_write,
    tap_stream_if.sink taps
);

    localparam acc_t CLAMP = acc_t'(`OUT_MAX);
    localparam int   OUT_CNT_W = $clog2(`FMAP_DIM * `FMAP_DIM / 4);

    acc_t                 acc;
    acc_t                 prod;
    acc_t                 win_sum;
    acc_t                 relu;
    acc_t                 pool_max;
    acc_t                 pool_next;
    logic [OUT_CNT_W-1:0] wr_cnt;

    always_comb
    begin
        prod      = acc_t'(taps.pixel) * acc_t'(taps.weight);
        win_sum   = acc + prod;
        relu      = (win_sum < acc_t'(0)) ? acc_t'(0) : win_sum;
        pool_next = (relu > pool_max) ? relu : pool_max;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            acc          <= '0;
            pool_max     <= '0;
            wr_cnt       <= '0;
            o_wr_en      <= 1'b0;
            o_last_write <= 1'b0;
        end
        else
        begin
            o_wr_en      <= 1'b0;
            o_last_write <= 1'b0;
            if (taps.tap_valid)
            begin
                if (taps.last_tap)
                begin
                    acc <= '0;
                    // relu output is never negative, so zero seeds the max
                    pool_max <= taps.quad_last ? acc_t'(0) : pool_next;
                end
                else
                begin
                    acc <= win_sum;
                end
                if (taps.quad_last)
                begin
                    o_wr_en      <= 1'b1;
                    o_last_write <= &wr_cnt;
                    wr_cnt       <= wr_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (taps.tap_valid && taps.quad_last)
        begin
            o_wr_addr <= i_wr_base + dram_addr_t'(wr_cnt);
            o_wr_data <= (pool_next > CLAMP) ? pixel_t'(`OUT_MAX) : pixel_t'(pool_next);
        end
    end

endmodule

// ==== hdl/dram_loader.sv ====
`include "cnn_settings.svh"

module dram_loader
    import cnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  dram_addr_t i_rd_base,
    input  pixel_t     i_rd_data1,
    input  pixel_t     i_rd_data2,
    output dram_addr_t o_rd_addr1,
    output dram_addr_t o_rd_addr2,
    output logic       o_load_done,
    buf_fill_if.filler fill
);

    localparam int N_WEIGHTS = `KERNEL_TAPS;
    localparam int N_PAIRS   = `FMAP_DIM * `FMAP_DIM / 2;
    localparam int CNT_W     = $clog2(N_WEIGHTS + N_PAIRS);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(N_WEIGHTS + N_PAIRS - 1);

    logic [CNT_W-1:0] fetch_cnt;
    logic [CNT_W-1:0] pair_idx;
    logic [CNT_W-1:0] fill_cnt;
    logic             busy;
    logic             fill_valid;
    logic             fetch_weight;
    logic             fill_weight;
    dram_addr_t       fetch_off;

    always_comb
    begin
        fetch_weight = (fetch_cnt < CNT_W'(N_WEIGHTS));
        pair_idx     = fetch_cnt - CNT_W'(N_WEIGHTS);
        if (fetch_weight)
        begin
            fetch_off = dram_addr_t'(fetch_cnt);
        end
        else
        begin
            // two row-major neighbours per cycle
            fetch_off = dram_addr_t'(`PIX_OFFSET) + dram_addr_t'({pair_idx, 1'b0});
        end
    end

    assign o_rd_addr1 = i_rd_base + fetch_off;
    assign o_rd_addr2 = fetch_weight ? o_rd_addr1 : o_rd_addr1 + dram_addr_t'(1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fetch_cnt  <= '0;
            busy       <= 1'b1;
            fill_valid <= 1'b0;
        end
        else
        begin
            fill_valid <= busy;
            if (busy)
            begin
                if (fetch_cnt == LAST_CNT)
                    busy <= 1'b0;
                else
                    fetch_cnt <= fetch_cnt + 1'b1;
            end
        end
    end

    // count follows the DRAM read latency
    always_ff @(posedge clk)
    begin
        fill_cnt <= fetch_cnt;
    end

    assign fill_weight = (fill_cnt < CNT_W'(N_WEIGHTS));

    assign fill.w_we     = fill_valid && fill_weight;
    assign fill.w_addr   = tap_idx_t'(fill_cnt);
    assign fill.w_data   = i_rd_data1;
    assign fill.pix_we   = fill_valid && !fill_weight;
    assign fill.pix_addr = bank_addr_t'(fill_cnt - CNT_W'(N_WEIGHTS));
    assign fill.pix_even = i_rd_data1;
    assign fill.pix_odd  = i_rd_data2;

    assign o_load_done = fill_valid && (fill_cnt == LAST_CNT);

endmodule

// ==== hdl/layer_sequencer.sv ====
module layer_sequencer
    import cnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  dram_addr_t i_rd_base,
    input  dram_addr_t i_wr_base,
    input  logic       i_load_done,
    input  logic       i_last_write,
    output dram_addr_t o_rd_base,
    output dram_addr_t o_wr_base,
    output logic       o_scan_start,
    output logic       o_done
);

    layer_phase_e phase;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // bases are sampled for as long as reset is held
            o_rd_base    <= i_rd_base;
            o_wr_base    <= i_wr_base;
            phase        <= PH_LOAD;
            o_scan_start <= 1'b0;
        end
        else
        begin
            o_scan_start <= 1'b0;
            case (phase)
                PH_LOAD:
                begin
                    if (i_load_done)
                    begin
                        phase        <= PH_COMPUTE;
                        o_scan_start <= 1'b1;
                    end
                end
                PH_COMPUTE:
                begin
                    if (i_last_write)
                    begin
                        phase <= PH_DONE;
                    end
                end
                default:
                begin
                    phase <= PH_DONE;
                end
            endcase
        end
    end

    assign o_done = (phase == PH_DONE);

endmodule

// ==== hdl/sram_dp.sv ====
module sram_dp
#(
    parameter type T_WORD = logic [7:0],
    parameter int  DEPTH  = 32
)
(
    input  logic                     clk,
    input  logic                     i_we,
    input  logic [$clog2(DEPTH)-1:0] i_waddr,
    input  T_WORD                    i_wdata,
    input  logic [$clog2(DEPTH)-1:0] i_raddr,
    output T_WORD                    o_rdata
);

    T_WORD mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (i_we)
        begin
            mem[i_waddr] <= i_wdata;
        end
        // registered read, one cycle after the address
        o_rdata <= mem[i_raddr];
    end

endmodule

// ==== hdl/window_scanner.sv ====
`include "cnn_settings.svh"

module window_scanner
    import cnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       i_scan_start,
    input  pixel_t     i_bank_even,
    input  pixel_t     i_bank_odd,
    input  weight_t    i_weight,
    output bank_addr_t o_bank_raddr,
    output tap_idx_t   o_w_raddr,
    output logic       o_scan_done,
    tap_stream_if.source taps
);

    localparam coord_t LAST_ORIGIN = coord_t'(`FMAP_DIM - 2);
    localparam int     CW          = $bits(coord_t);

    logic       active;
    coord_t     quad_row;
    coord_t     quad_col;
    logic [1:0] win_cnt;
    logic [1:0] tap_row;
    logic [1:0] tap_col;

    // pixel index plus one, so the top and left pads stay non-negative
    logic [CW:0] row_ext;
    logic [CW:0] col_ext;
    coord_t      pix_row;
    coord_t      pix_col;
    logic        tap_pad;
    logic        last_tap;
    logic        quad_last;
    logic        final_tap;
    logic        parity_d;
    logic        pad_d;

    always_comb
    begin
        row_ext   = {1'b0, quad_row} + (CW+1)'(win_cnt[1]) + (CW+1)'(tap_row);
        col_ext   = {1'b0, quad_col} + (CW+1)'(win_cnt[0]) + (CW+1)'(tap_col);
        pix_row   = coord_t'(row_ext - 1'b1);
        pix_col   = coord_t'(col_ext - 1'b1);
        tap_pad   = (row_ext == '0) || (row_ext > (CW+1)'(`FMAP_DIM)) ||
                    (col_ext == '0) || (col_ext > (CW+1)'(`FMAP_DIM));
        last_tap  = (tap_row == 2'd2) && (tap_col == 2'd2);
        quad_last = last_tap && (win_cnt == 2'd3);
        final_tap = quad_last && (quad_row == LAST_ORIGIN) && (quad_col == LAST_ORIGIN);
    end

    // even and odd columns share one address per row
    assign o_bank_raddr = bank_addr_t'({pix_row, pix_col[CW-1:1]});
    assign o_w_raddr    = tap_idx_t'(4'(tap_row) * 4'd3 + 4'(tap_col));

    // quad order: (p,q) (p,q+1) (p+1,q) (p+1,q+1)
    always_ff @(posedge clk)
    begin
        if (reset || i_scan_start)
        begin
            active   <= i_scan_start && !reset;
            quad_row <= '0;
            quad_col <= '0;
            win_cnt  <= '0;
            tap_row  <= '0;
            tap_col  <= '0;
        end
        else if (active)
        begin
            if (tap_col == 2'd2)
            begin
                tap_col <= '0;
                if (tap_row == 2'd2)
                begin
                    tap_row <= '0;
                    win_cnt <= win_cnt + 1'b1;
                    if (win_cnt == 2'd3)
                    begin
                        if (quad_col == LAST_ORIGIN)
                        begin
                            quad_col <= '0;
                            quad_row <= quad_row + coord_t'(2);
                            if (quad_row == LAST_ORIGIN)
                                active <= 1'b0;
                        end
                        else
                        begin
                            quad_col <= quad_col + coord_t'(2);
                        end
                    end
                end
                else
                begin
                    tap_row <= tap_row + 1'b1;
                end
            end
            else
            begin
                tap_col <= tap_col + 1'b1;
            end
        end
    end

    // align with the sram read
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            taps.tap_valid <= 1'b0;
            taps.last_tap  <= 1'b0;
            taps.quad_last <= 1'b0;
            o_scan_done    <= 1'b0;
        end
        else
        begin
            taps.tap_valid <= active;
            taps.last_tap  <= active && last_tap;
            taps.quad_last <= active && quad_last;
            o_scan_done    <= active && final_tap;
        end
    end

    always_ff @(posedge clk)
    begin
        parity_d <= pix_col[0];
        pad_d    <= tap_pad;
    end

    assign taps.pixel  = pad_d ? pixel_t'(0) : (parity_d ? i_bank_odd : i_bank_even);
    assign taps.weight = i_weight;

endmodule

// ==== test/conv_patterns.hex ====
// line 1: kernel weights w0..w8 row-major, then eight image rows of eight pixels
// last two lines: sixteen expected pooled outputs in row-major order
01 00 00 00 02 00 00 00 ff
46 46 46 46 05 0a 0f 14
46 46 46 46 05 0a 0f 14
46 46 46 46 05 0a 0f 14
46 46 46 46 05 0a 0f 14
d8 d8 d8 d8 1e 1e 1e 1e
d8 d8 d8 d8 1e 1e 1e 1e
d8 d8 d8 d8 1e 1e 1e 1e
d8 d8 d8 d8 1e 1e 1e 1e
7f 7f 46 37 7f 7f 46 37
1e 1e 64 5a 00 00 5a 5a

// ==== test/tb_cnn_layer.sv ====
`include "cnn_settings.svh"

module tb_cnn_layer
    import cnn_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_OUT = `FMAP_DIM * `FMAP_DIM / 4;
    localparam int LAST_RD = `PIX_OFFSET + `FMAP_DIM * `FMAP_DIM - 1;

    logic       clk;
    logic       reset;
    dram_addr_t i_rd_base;
    dram_addr_t i_wr_base;
    dram_addr_t o_rd_addr1;
    dram_addr_t o_rd_addr2;
    pixel_t     i_rd_data1;
    pixel_t     i_rd_data2;
    logic       o_wr_en;
    dram_addr_t o_wr_addr;
    pixel_t     o_wr_data;
    logic       o_done;

    logic [7:0] pat_mem [0:88];
    logic [7:0] dram_mem [0:65535];
    int         cur_w [9];
    int         cur_pix [64];
    int         exp_now [16];
    dram_addr_t wr_addr_q [$];
    pixel_t     wr_data_q [$];
    bit         read_seen [0:LAST_RD];
    dram_addr_t lat_addr1;
    dram_addr_t lat_addr2;
    dram_addr_t rd_base_tb;
    dram_addr_t wr_base_tb;
    int         off1;
    int         off2;
    int         errors;
    int         checks;
    bit         timed_out;
    int         seed_val;

    cnn_layer_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .i_rd_base  (i_rd_base),
        .i_wr_base  (i_wr_base),
        .o_rd_addr1 (o_rd_addr1),
        .o_rd_addr2 (o_rd_addr2),
        .i_rd_data1 (i_rd_data1),
        .i_rd_data2 (i_rd_data2),
        .o_wr_en    (o_wr_en),
        .o_wr_addr  (o_wr_addr),
        .o_wr_data  (o_wr_data),
        .o_done     (o_done)
    );

    always #2 clk = ~clk;

    // read data returns one cycle after the address
    always @(posedge clk)
    begin
        #1;
        i_rd_data1 = pixel_t'(dram_mem[lat_addr1]);
        i_rd_data2 = pixel_t'(dram_mem[lat_addr2]);
    end

    always @(negedge clk)
    begin
        lat_addr1 = o_rd_addr1;
        lat_addr2 = o_rd_addr2;
        if (!reset)
        begin
            off1 = int'(o_rd_addr1) - int'(rd_base_tb);
            off2 = int'(o_rd_addr2) - int'(rd_base_tb);
            if (off1 < 0 || off1 > LAST_RD)
            begin
                errors++;
                $display("ERR o_rd_addr1: %h outside %h..%h", o_rd_addr1, rd_base_tb,
                         rd_base_tb + dram_addr_t'(LAST_RD));
            end
            else
            begin
                read_seen[off1] = 1'b1;
            end
            if (off2 < 0 || off2 > LAST_RD)
            begin
                errors++;
                $display("ERR o_rd_addr2: %h outside %h..%h", o_rd_addr2, rd_base_tb,
                         rd_base_tb + dram_addr_t'(LAST_RD));
            end
            else
            begin
                read_seen[off2] = 1'b1;
            end
            // done may only follow a completed sixteenth write
            if (o_done && wr_addr_q.size() < N_OUT)
            begin
                errors++;
                $display("o_done is high after only %0d writes", wr_addr_q.size());
            end
            // write log
            if (o_wr_en)
            begin
                wr_addr_q.push_back(o_wr_addr);
                wr_data_q.push_back(o_wr_data);
            end
        end
    end

    function automatic int pixel_at(int r, int c);
        if (r < 0 || r >= `FMAP_DIM || c < 0 || c >= `FMAP_DIM)
            return 0;
        else
            return cur_pix[r * `FMAP_DIM + c];
    endfunction

    // zero-padded 3x3 sum, relu, max over the quad, clamp
    function automatic int expected_out(int i, int j);
        int best;
        int sum;
        best = 0;
        for (int wr = 0; wr < 2; wr++)
        begin
            for (int wc = 0; wc < 2; wc++)
            begin
                sum = 0;
                for (int dr = -1; dr <= 1; dr++)
                begin
                    for (int dc = -1; dc <= 1; dc++)
                    begin
                        sum += cur_w[3 * (dr + 1) + dc + 1] *
                               pixel_at(2 * i + wr + dr, 2 * j + wc + dc);
                    end
                end
                if (sum > best)
                    best = sum;
            end
        end
        if (best > `OUT_MAX)
            best = `OUT_MAX;
        return best;
    endfunction

    task automatic load_dram(input dram_addr_t base);
        for (int k = 0; k < `KERNEL_TAPS; k++)
            dram_mem[base + dram_addr_t'(k)] = 8'(cur_w[k]);
        for (int n = 0; n < 64; n++)
            dram_mem[base + dram_addr_t'(`PIX_OFFSET + n)] = 8'(cur_pix[n]);
    endtask

    task automatic check_idle();
        checks++;
        if (o_wr_en !== 1'b0)
        begin
            errors++;
            $display("ERR o_wr_en: got %h expected 0", o_wr_en);
        end
        if (o_done !== 1'b0)
        begin
            errors++;
            $display("ERR o_done: got %h expected 0", o_done);
        end
    endtask

    task automatic apply_reset(input dram_addr_t rb, input dram_addr_t wb);
        reset = 1'b1;
        i_rd_base = rb;
        i_wr_base = wb;
        rd_base_tb = rb;
        wr_base_tb = wb;
        wr_addr_q.delete();
        wr_data_q.delete();
        for (int k = 0; k <= LAST_RD; k++)
            read_seen[k] = 1'b0;
        repeat (5)
        begin
            @(posedge clk);
            #1;
            check_idle();
        end
        reset = 1'b0;
        repeat (3)
        begin
            @(posedge clk);
            #1;
            check_idle();
        end
    endtask

    task automatic wait_writes(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (wr_addr_q.size() < n && cycles < limit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (wr_addr_q.size() < n)
        begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: only %0d of %0d writes seen", wr_addr_q.size(), n);
        end
    endtask

    task automatic wait_done(input int limit);
        int cycles;
        cycles = 0;
        while (o_done !== 1'b1 && cycles < limit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (o_done !== 1'b1)
        begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: o_done never rose after the last write");
        end
    endtask

    task automatic check_layer();
        repeat (100)
        begin
            @(posedge clk);
            #1;
            checks++;
            if (o_done !== 1'b1)
            begin
                errors++;
                $display("ERR o_done: got %h expected 1", o_done);
            end
        end
        for (int k = 0; k <= LAST_RD; k++)
        begin
            if (!read_seen[k])
            begin
                errors++;
                $display("DRAM address %h was never read", rd_base_tb + dram_addr_t'(k));
            end
        end
        checks++;
        if (wr_addr_q.size() != N_OUT)
        begin
            errors++;
            $display("expected %0d writes but saw %0d", N_OUT, wr_addr_q.size());
        end
        for (int i = 0; i < wr_addr_q.size() && i < N_OUT; i++)
        begin
            checks++;
            if (wr_addr_q[i] !== wr_base_tb + dram_addr_t'(i))
            begin
                errors++;
                $display("ERR o_wr_addr[%0d]: got %h expected %h", i, wr_addr_q[i],
                         wr_base_tb + dram_addr_t'(i));
            end
            if (wr_data_q[i] !== pixel_t'(exp_now[i]))
            begin
                errors++;
                $display("ERR o_wr_data[%0d]: got %h expected %h", i, wr_data_q[i],
                         pixel_t'(exp_now[i]));
            end
        end
    endtask

    task automatic run_layer(input dram_addr_t rb, input dram_addr_t wb);
        load_dram(rb);
        apply_reset(rb, wb);
        wait_writes(N_OUT, 1500);
        if (!timed_out)
            wait_done(50);
        if (!timed_out)
            check_layer();
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        i_rd_base = '0;
        i_wr_base = '0;
        i_rd_data1 = '0;
        i_rd_data2 = '0;
        lat_addr1 = '0;
        lat_addr2 = '0;
        rd_base_tb = '0;
        wr_base_tb = '0;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        seed_val = $urandom(58);
        for (int a = 0; a < 65536; a++)
            dram_mem[a] = 8'(a ^ (a >> 8) ^ 8'h5a);
        $readmemh("test/conv_patterns.hex", pat_mem);

        // run 1 uses the fixed image from the data file
        for (int k = 0; k < `KERNEL_TAPS; k++)
            cur_w[k] = $signed(pat_mem[k]);
        for (int n = 0; n < 64; n++)
            cur_pix[n] = $signed(pat_mem[`PIX_OFFSET + n]);
        for (int i = 0; i < N_OUT; i++)
        begin
            exp_now[i] = pat_mem[73 + i];
            checks++;
            if (expected_out(i / 4, i % 4) != exp_now[i])
            begin
                errors++;
                $display("ERR model out[%0d]: got %h expected %h", i,
                         expected_out(i / 4, i % 4), exp_now[i]);
            end
        end
        run_layer(16'h0100, 16'h0800);

        // run 2 draws weights and pixels from -16..15
        if (!timed_out)
        begin
            for (int k = 0; k < `KERNEL_TAPS; k++)
                cur_w[k] = int'($urandom() % 32) - 16;
            for (int n = 0; n < 64; n++)
                cur_pix[n] = int'($urandom() % 32) - 16;
            for (int i = 0; i < N_OUT; i++)
                exp_now[i] = expected_out(i / 4, i % 4);
            run_layer(16'h2000, 16'h0040);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
